// File: hw/axi_perf_pkg.sv
package axi_perf_pkg;

  // Beat width. The data word union below is built on four byte lanes.
  localparam int DATA_BYTES = 4;
  localparam int DATA_WIDTH = 8 * DATA_BYTES;

  // Upper bit is the arbiter port, lower bit the writer tag.
  localparam int ID_WIDTH = 2;

  localparam logic [1:0] BURST_INCR = 2'b01;
  localparam logic [2:0] SIZE_WORD = 3'($clog2(DATA_BYTES));

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // One beat, seen either as a whole word or as byte lanes.
  typedef union packed {
    logic [DATA_WIDTH-1:0] word;
    logic [DATA_BYTES-1:0][7:0] bytes;
  } data_word_t;

endpackage

// File: hw/axi_burst_writer.sv
`timescale 1ns/1ps

module axi_burst_writer #(
  parameter int ADDR_WIDTH = 16,
  parameter int BURST_LEN = 8,
  parameter int NUM_BURSTS = 4,
  parameter logic WRITER_ID = 1'b0
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic [ADDR_WIDTH-1:0] base_addr,
  input  logic [axi_perf_pkg::DATA_BYTES-1:0] byte_mask,
  output logic aw_valid,
  input  logic aw_ready,
  output logic [ADDR_WIDTH-1:0] aw_addr,
  output logic [axi_perf_pkg::ID_WIDTH-2:0] aw_id,
  output logic [7:0] aw_len,
  output logic [2:0] aw_size,
  output logic [1:0] aw_burst,
  output logic w_valid,
  input  logic w_ready,
  output logic [axi_perf_pkg::DATA_WIDTH-1:0] w_data,
  output logic [axi_perf_pkg::DATA_BYTES-1:0] w_strb,
  output logic w_last,
  input  logic b_valid,
  output logic b_ready,
  input  logic [axi_perf_pkg::ID_WIDTH-2:0] b_id,
  input  logic [1:0] b_resp,
  output logic done,
  output logic busy,
  output logic error,
  output logic [15:0] beat_count,
  output logic [31:0] cycle_count
);
  import axi_perf_pkg::*;

  localparam int BURST_BYTES = BURST_LEN * DATA_BYTES;

  logic [ADDR_WIDTH-1:0] base_q;
  logic [DATA_BYTES-1:0] mask_q;
  logic [7:0] burst_idx;
  logic [7:0] beat_idx;
  logic [7:0] resp_cnt;
  logic aw_fire;
  logic w_fire;
  logic b_fire;
  data_word_t beat_word;

  assign aw_fire = aw_valid && aw_ready;
  assign w_fire = w_valid && w_ready;
  assign b_fire = b_valid && b_ready;

  // Bursts are laid out back to back from the base address.
  assign aw_addr = base_q + ADDR_WIDTH'(int'(burst_idx) * BURST_BYTES);
  assign aw_id = WRITER_ID;
  assign aw_len = 8'(BURST_LEN - 1);
  assign aw_size = SIZE_WORD;
  assign aw_burst = BURST_INCR;

  // Writer tag, burst number and beat number make every beat unique.
  always_comb begin
    beat_word = '0;
    beat_word.word[31] = WRITER_ID;
    beat_word.word[23:16] = burst_idx;
    beat_word.word[7:0] = beat_idx;
  end

  assign w_data = beat_word.word;
  assign w_strb = mask_q;
  assign w_last = beat_idx == 8'(BURST_LEN - 1);
  assign b_ready = busy;

  always_ff @(posedge clk) begin
    if (start && !busy) begin
      base_q <= base_addr;
      mask_q <= byte_mask;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      error <= 1'b0;
      aw_valid <= 1'b0;
      w_valid <= 1'b0;
      burst_idx <= '0;
      beat_idx <= '0;
      resp_cnt <= '0;
      beat_count <= '0;
      cycle_count <= '0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        busy <= 1'b1;
        aw_valid <= 1'b1;
        w_valid <= 1'b0;
        error <= 1'b0;
        burst_idx <= '0;
        beat_idx <= '0;
        resp_cnt <= '0;
        beat_count <= '0;
        cycle_count <= '0;
      end else if (busy) begin
        cycle_count <= cycle_count + 32'd1;
        if (aw_fire) begin
          aw_valid <= 1'b0;
          w_valid <= 1'b1;
        end
        // Next address goes out once this burst's data is all sent.
        if (w_fire) begin
          beat_count <= beat_count + 16'd1;
          beat_idx <= w_last ? 8'd0 : beat_idx + 8'd1;
          if (w_last) begin
            w_valid <= 1'b0;
            burst_idx <= burst_idx + 8'd1;
            aw_valid <= burst_idx != 8'(NUM_BURSTS - 1);
          end
        end
        if (b_fire) begin
          resp_cnt <= resp_cnt + 8'd1;
          if (b_resp != RESP_OKAY || b_id != aw_id) begin
            error <= 1'b1;
          end
          if (resp_cnt == 8'(NUM_BURSTS - 1)) begin
            busy <= 1'b0;
            done <= 1'b1;
          end
        end
      end
    end
  end

  a_len_max: assert property (@(posedge clk) aw_valid |-> aw_len < 8'd16);

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr));

  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_strb) && $stable(w_last));

endmodule

// File: hw/axi_write_arbiter.sv
`timescale 1ns/1ps

module axi_write_arbiter #(
  parameter int ADDR_WIDTH = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic m0_aw_valid,
  output logic m0_aw_ready,
  input  logic [ADDR_WIDTH-1:0] m0_aw_addr,
  input  logic [axi_perf_pkg::ID_WIDTH-2:0] m0_aw_id,
  input  logic [7:0] m0_aw_len,
  input  logic [2:0] m0_aw_size,
  input  logic [1:0] m0_aw_burst,
  input  logic m0_w_valid,
  output logic m0_w_ready,
  input  logic [axi_perf_pkg::DATA_WIDTH-1:0] m0_w_data,
  input  logic [axi_perf_pkg::DATA_BYTES-1:0] m0_w_strb,
  input  logic m0_w_last,
  output logic m0_b_valid,
  input  logic m0_b_ready,
  output logic [axi_perf_pkg::ID_WIDTH-2:0] m0_b_id,
  output logic [1:0] m0_b_resp,
  input  logic m1_aw_valid,
  output logic m1_aw_ready,
  input  logic [ADDR_WIDTH-1:0] m1_aw_addr,
  input  logic [axi_perf_pkg::ID_WIDTH-2:0] m1_aw_id,
  input  logic [7:0] m1_aw_len,
  input  logic [2:0] m1_aw_size,
  input  logic [1:0] m1_aw_burst,
  input  logic m1_w_valid,
  output logic m1_w_ready,
  input  logic [axi_perf_pkg::DATA_WIDTH-1:0] m1_w_data,
  input  logic [axi_perf_pkg::DATA_BYTES-1:0] m1_w_strb,
  input  logic m1_w_last,
  output logic m1_b_valid,
  input  logic m1_b_ready,
  output logic [axi_perf_pkg::ID_WIDTH-2:0] m1_b_id,
  output logic [1:0] m1_b_resp,
  output logic s_aw_valid,
  input  logic s_aw_ready,
  output logic [ADDR_WIDTH-1:0] s_aw_addr,
  output logic [axi_perf_pkg::ID_WIDTH-1:0] s_aw_id,
  output logic [7:0] s_aw_len,
  output logic [2:0] s_aw_size,
  output logic [1:0] s_aw_burst,
  output logic s_w_valid,
  input  logic s_w_ready,
  output logic [axi_perf_pkg::DATA_WIDTH-1:0] s_w_data,
  output logic [axi_perf_pkg::DATA_BYTES-1:0] s_w_strb,
  output logic s_w_last,
  input  logic s_b_valid,
  output logic s_b_ready,
  input  logic [axi_perf_pkg::ID_WIDTH-1:0] s_b_id,
  input  logic [1:0] s_b_resp
);
  import axi_perf_pkg::*;

  logic lock;
  logic w_port;
  logic last_grant;
  logic aw_hold;
  logic aw_sel_q;
  logic aw_sel;
  logic b_port;

  // A stalled grant is kept so the address on the sink side stays put.
  always_comb begin
    if (aw_hold) begin
      aw_sel = aw_sel_q;
    end else if (m0_aw_valid && m1_aw_valid) begin
      aw_sel = !last_grant;
    end else begin
      aw_sel = m1_aw_valid;
    end
  end

  assign s_aw_valid = !lock && (m0_aw_valid || m1_aw_valid);
  assign s_aw_addr = aw_sel ? m1_aw_addr : m0_aw_addr;
  assign s_aw_id = {aw_sel, aw_sel ? m1_aw_id : m0_aw_id};
  assign s_aw_len = aw_sel ? m1_aw_len : m0_aw_len;
  assign s_aw_size = aw_sel ? m1_aw_size : m0_aw_size;
  assign s_aw_burst = aw_sel ? m1_aw_burst : m0_aw_burst;
  assign m0_aw_ready = !lock && !aw_sel && s_aw_ready;
  assign m1_aw_ready = !lock && aw_sel && s_aw_ready;

  assign s_w_valid = lock && (w_port ? m1_w_valid : m0_w_valid);
  assign s_w_data = w_port ? m1_w_data : m0_w_data;
  assign s_w_strb = w_port ? m1_w_strb : m0_w_strb;
  assign s_w_last = w_port ? m1_w_last : m0_w_last;
  assign m0_w_ready = lock && !w_port && s_w_ready;
  assign m1_w_ready = lock && w_port && s_w_ready;

  // Responses find their port from the tag added on the way out.
  assign b_port = s_b_id[ID_WIDTH-1];
  assign m0_b_valid = s_b_valid && !b_port;
  assign m1_b_valid = s_b_valid && b_port;
  assign m0_b_id = s_b_id[ID_WIDTH-2:0];
  assign m1_b_id = s_b_id[ID_WIDTH-2:0];
  assign m0_b_resp = s_b_resp;
  assign m1_b_resp = s_b_resp;
  assign s_b_ready = b_port ? m1_b_ready : m0_b_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      lock <= 1'b0;
      w_port <= 1'b0;
      last_grant <= 1'b1;
      aw_hold <= 1'b0;
      aw_sel_q <= 1'b0;
    end else begin
      if (s_aw_valid && s_aw_ready) begin
        lock <= 1'b1;
        w_port <= aw_sel;
        last_grant <= aw_sel;
        aw_hold <= 1'b0;
      end else if (s_aw_valid) begin
        aw_hold <= 1'b1;
        aw_sel_q <= aw_sel;
      end
      if (s_w_valid && s_w_ready && s_w_last) begin
        lock <= 1'b0;
      end
    end
  end

  // A stalled address keeps its winner until the sink takes it.
  a_one_grant: assert property (@(posedge clk) disable iff (rst)
    s_aw_valid && !s_aw_ready |=> s_aw_valid && $stable(s_aw_id[ID_WIDTH-1]));

endmodule

// File: hw/axi_mem_sink.sv
`timescale 1ns/1ps

module axi_mem_sink #(
  parameter int ADDR_WIDTH = 16,
  parameter int MEM_DEPTH = 1024
) (
  input  logic clk,
  input  logic rst,
  input  logic aw_valid,
  output logic aw_ready,
  input  logic [ADDR_WIDTH-1:0] aw_addr,
  input  logic [axi_perf_pkg::ID_WIDTH-1:0] aw_id,
  input  logic [7:0] aw_len,
  input  logic [2:0] aw_size,
  input  logic [1:0] aw_burst,
  input  logic w_valid,
  output logic w_ready,
  input  logic [axi_perf_pkg::DATA_WIDTH-1:0] w_data,
  input  logic [axi_perf_pkg::DATA_BYTES-1:0] w_strb,
  input  logic w_last,
  output logic b_valid,
  input  logic b_ready,
  output logic [axi_perf_pkg::ID_WIDTH-1:0] b_id,
  output logic [1:0] b_resp,
  input  logic [$clog2(MEM_DEPTH)-1:0] dbg_addr,
  output axi_perf_pkg::data_word_t dbg_data
);
  import axi_perf_pkg::*;

  localparam int IDX_W = $clog2(MEM_DEPTH);
  localparam int LANE_SHIFT = $clog2(DATA_BYTES);

  data_word_t mem [MEM_DEPTH];
  data_word_t w_word;
  data_word_t merged;
  logic in_burst;
  logic b_pending;
  logic bad;
  logic aw_reject;
  logic [IDX_W-1:0] wr_idx;
  logic [7:0] beats_left;
  logic [ADDR_WIDTH:0] aw_last_word;

  assign aw_ready = !in_burst && !b_pending;
  assign w_ready = in_burst;
  assign b_valid = b_pending;

  // Word index of the final beat, one bit wider so it cannot wrap.
  assign aw_last_word = (ADDR_WIDTH + 1)'(aw_addr >> LANE_SHIFT) + (ADDR_WIDTH + 1)'(aw_len);
  assign aw_reject = aw_last_word >= (ADDR_WIDTH + 1)'(MEM_DEPTH)
                  || aw_burst != BURST_INCR || aw_size != SIZE_WORD;

  // Strobed lanes replace the stored bytes, the rest keep their value.
  always_comb begin
    w_word.word = w_data;
    merged = mem[wr_idx];
    for (int i = 0; i < DATA_BYTES; i++) begin
      if (w_strb[i]) begin
        merged.bytes[i] = w_word.bytes[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_burst <= 1'b0;
      b_pending <= 1'b0;
    end else begin
      if (aw_valid && aw_ready) begin
        in_burst <= 1'b1;
      end
      if (w_valid && w_ready && w_last) begin
        in_burst <= 1'b0;
        b_pending <= 1'b1;
      end
      if (b_valid && b_ready) begin
        b_pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) begin
      wr_idx <= aw_addr[LANE_SHIFT +: IDX_W];
      beats_left <= aw_len;
      bad <= aw_reject;
      b_id <= aw_id;
    end else if (w_valid && w_ready) begin
      wr_idx <= wr_idx + IDX_W'(1);
      beats_left <= beats_left - 8'd1;
    end
    if (w_valid && w_ready && w_last) begin
      b_resp <= bad ? RESP_DECERR : RESP_OKAY;
    end
  end

  always_ff @(posedge clk) begin
    if (w_valid && w_ready && !bad) begin
      mem[wr_idx] <= merged;
    end
    dbg_data <= mem[dbg_addr];
  end

  // The burst closes on the beat its length names, and no beat comes after it.
  a_w_open: assert property (@(posedge clk) disable iff (rst)
    w_valid && w_ready |-> w_last == (beats_left == 8'd0));

endmodule

// File: hw/axi_perf_top.sv
`timescale 1ns/1ps

module axi_perf_top #(
  parameter int ADDR_WIDTH = 16,
  parameter int MEM_DEPTH = 1024,
  parameter int BURST_LEN = 8,
  parameter int NUM_BURSTS = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic start0,
  input  logic start1,
  input  logic [ADDR_WIDTH-1:0] base_addr0,
  input  logic [ADDR_WIDTH-1:0] base_addr1,
  input  logic [axi_perf_pkg::DATA_BYTES-1:0] byte_mask0,
  input  logic [axi_perf_pkg::DATA_BYTES-1:0] byte_mask1,
  output logic done0,
  output logic done1,
  output logic error0,
  output logic error1,
  output logic [15:0] beat_count0,
  output logic [15:0] beat_count1,
  output logic [31:0] cycle_count0,
  output logic [31:0] cycle_count1,
  input  logic [$clog2(MEM_DEPTH)-1:0] dbg_addr,
  output axi_perf_pkg::data_word_t dbg_data
);
  import axi_perf_pkg::*;

  logic m0_aw_valid, m0_aw_ready, m0_w_valid, m0_w_ready, m0_w_last, m0_b_valid, m0_b_ready;
  logic m1_aw_valid, m1_aw_ready, m1_w_valid, m1_w_ready, m1_w_last, m1_b_valid, m1_b_ready;
  logic s_aw_valid, s_aw_ready, s_w_valid, s_w_ready, s_w_last, s_b_valid, s_b_ready;
  logic [ADDR_WIDTH-1:0] m0_aw_addr, m1_aw_addr, s_aw_addr;
  logic [ID_WIDTH-2:0] m0_aw_id, m1_aw_id, m0_b_id, m1_b_id;
  logic [ID_WIDTH-1:0] s_aw_id, s_b_id;
  logic [7:0] m0_aw_len, m1_aw_len, s_aw_len;
  logic [2:0] m0_aw_size, m1_aw_size, s_aw_size;
  logic [1:0] m0_aw_burst, m1_aw_burst, s_aw_burst;
  logic [1:0] m0_b_resp, m1_b_resp, s_b_resp;
  logic [DATA_WIDTH-1:0] m0_w_data, m1_w_data, s_w_data;
  logic [DATA_BYTES-1:0] m0_w_strb, m1_w_strb, s_w_strb;

  axi_burst_writer #(
    .ADDR_WIDTH(ADDR_WIDTH), .BURST_LEN(BURST_LEN), .NUM_BURSTS(NUM_BURSTS), .WRITER_ID(1'b0)
  ) u_writer0 (
    .clk(clk), .rst(rst), .start(start0), .base_addr(base_addr0), .byte_mask(byte_mask0),
    .aw_valid(m0_aw_valid), .aw_ready(m0_aw_ready), .aw_addr(m0_aw_addr), .aw_id(m0_aw_id),
    .aw_len(m0_aw_len), .aw_size(m0_aw_size), .aw_burst(m0_aw_burst),
    .w_valid(m0_w_valid), .w_ready(m0_w_ready), .w_data(m0_w_data), .w_strb(m0_w_strb),
    .w_last(m0_w_last), .b_valid(m0_b_valid), .b_ready(m0_b_ready), .b_id(m0_b_id),
    .b_resp(m0_b_resp), .done(done0), .busy(), .error(error0),
    .beat_count(beat_count0), .cycle_count(cycle_count0)
  );

  axi_burst_writer #(
    .ADDR_WIDTH(ADDR_WIDTH), .BURST_LEN(BURST_LEN), .NUM_BURSTS(NUM_BURSTS), .WRITER_ID(1'b1)
  ) u_writer1 (
    .clk(clk), .rst(rst), .start(start1), .base_addr(base_addr1), .byte_mask(byte_mask1),
    .aw_valid(m1_aw_valid), .aw_ready(m1_aw_ready), .aw_addr(m1_aw_addr), .aw_id(m1_aw_id),
    .aw_len(m1_aw_len), .aw_size(m1_aw_size), .aw_burst(m1_aw_burst),
    .w_valid(m1_w_valid), .w_ready(m1_w_ready), .w_data(m1_w_data), .w_strb(m1_w_strb),
    .w_last(m1_w_last), .b_valid(m1_b_valid), .b_ready(m1_b_ready), .b_id(m1_b_id),
    .b_resp(m1_b_resp), .done(done1), .busy(), .error(error1),
    .beat_count(beat_count1), .cycle_count(cycle_count1)
  );

  // Port names on the arbiter match the wires above one for one.
  axi_write_arbiter #(.ADDR_WIDTH(ADDR_WIDTH)) u_arbiter (.*);

  axi_mem_sink #(.ADDR_WIDTH(ADDR_WIDTH), .MEM_DEPTH(MEM_DEPTH)) u_sink (
    .clk(clk), .rst(rst),
    .aw_valid(s_aw_valid), .aw_ready(s_aw_ready), .aw_addr(s_aw_addr), .aw_id(s_aw_id),
    .aw_len(s_aw_len), .aw_size(s_aw_size), .aw_burst(s_aw_burst),
    .w_valid(s_w_valid), .w_ready(s_w_ready), .w_data(s_w_data), .w_strb(s_w_strb),
    .w_last(s_w_last), .b_valid(s_b_valid), .b_ready(s_b_ready), .b_id(s_b_id),
    .b_resp(s_b_resp), .dbg_addr(dbg_addr), .dbg_data(dbg_data)
  );

endmodule

// File: sim/axi_perf_tb.sv
`timescale 1ns/1ps

module axi_perf_tb;
  import axi_perf_pkg::*;

  localparam int ADDR_WIDTH = 16;
  localparam int MEM_DEPTH = 1024;
  localparam int BURST_LEN = 8;
  localparam int NUM_BURSTS = 4;
  localparam int RUN_WORDS = NUM_BURSTS * BURST_LEN;
  localparam int IDX_W = $clog2(MEM_DEPTH);
  localparam int NUM_TESTS = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * NUM_BURSTS * BURST_LEN * 50;

  logic clk;
  logic rst;
  logic start0, start1;
  logic [ADDR_WIDTH-1:0] base_addr0, base_addr1;
  logic [DATA_BYTES-1:0] byte_mask0, byte_mask1;
  logic done0, done1, error0, error1;
  logic [15:0] beat_count0, beat_count1;
  logic [31:0] cycle_count0, cycle_count1;
  logic [IDX_W-1:0] dbg_addr;
  data_word_t dbg_data;

  // Expected memory, and which bytes of each word have a known value.
  data_word_t model [MEM_DEPTH];
  logic [DATA_BYTES-1:0] known [MEM_DEPTH];
  logic [31:0] rng;
  int errors;
  int test_errors;
  int failed_tests;

  axi_perf_top #(
    .ADDR_WIDTH(ADDR_WIDTH), .MEM_DEPTH(MEM_DEPTH), .BURST_LEN(BURST_LEN), .NUM_BURSTS(NUM_BURSTS)
  ) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #((WATCHDOG_CYCLES + 16) * 8);
    $display("Watchdog expired after %0d cycles, a run never finished", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int pick(input int span);
    rng = xorshift32(rng);
    return int'(rng % 32'(span));
  endfunction

  function automatic logic [DATA_BYTES-1:0] partial_mask();
    return DATA_BYTES'(pick(14) + 1);
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] byte_addr(input int word);
    return ADDR_WIDTH'(word * DATA_BYTES);
  endfunction

  // Writer tag in bit 31, burst in bits 23:16, beat in bits 7:0.
  function automatic data_word_t beat_data(input logic id, input int burst, input int beat);
    data_word_t d;
    d.word = '0;
    d.word[31] = id;
    d.word[23:16] = 8'(burst);
    d.word[7:0] = 8'(beat);
    return d;
  endfunction

  task automatic model_run(input logic id, input int base_word, input logic [DATA_BYTES-1:0] mask);
    int w;
    data_word_t d;
    for (int k = 0; k < NUM_BURSTS; k++) begin
      for (int j = 0; j < BURST_LEN; j++) begin
        w = base_word + k * BURST_LEN + j;
        d = beat_data(id, k, j);
        for (int i = 0; i < DATA_BYTES; i++) begin
          if (mask[i]) begin
            model[w].bytes[i] = d.bytes[i];
          end
        end
        known[w] = known[w] | mask;
      end
    end
  endtask

  task automatic check_word(input data_word_t exp, input data_word_t act, input int idx);
    if (act !== exp) begin
      $display("Fail at %0t: word %0d expected %h, read %h", $time, idx, exp.word, act.word);
      errors++;
    end
  endtask

  task automatic check_count(input logic [31:0] act, input logic [31:0] lo,
                             input logic [31:0] hi, input string what);
    if (act < lo || act > hi) begin
      $display("Fail at %0t: %s is %0d, expected %0d to %0d", $time, what, act, lo, hi);
      errors++;
    end
  endtask

  task automatic check_flag(input logic exp, input logic act, input string what);
    if (act !== exp) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, what, act, exp);
      errors++;
    end
  endtask

  // Debug read returns the word one cycle after the address.
  task automatic read_word(input int idx, output data_word_t value);
    @(posedge clk);
    dbg_addr <= IDX_W'(idx);
    @(posedge clk);
    @(negedge clk);
    value = dbg_data;
  endtask

  task automatic check_memory();
    data_word_t value;
    for (int w = 0; w < MEM_DEPTH; w++) begin
      if (known[w] == '1) begin
        read_word(w, value);
        check_word(model[w], value, w);
      end
    end
  endtask

  task automatic start_pair(input logic go0, input logic go1,
                            input logic [ADDR_WIDTH-1:0] addr0, input logic [ADDR_WIDTH-1:0] addr1,
                            input logic [DATA_BYTES-1:0] mask0, input logic [DATA_BYTES-1:0] mask1);
    @(posedge clk);
    start0 <= go0;
    start1 <= go1;
    base_addr0 <= addr0;
    base_addr1 <= addr1;
    byte_mask0 <= mask0;
    byte_mask1 <= mask1;
    @(posedge clk);
    start0 <= 1'b0;
    start1 <= 1'b0;
  endtask

  // Returns the writer whose done came first.
  task automatic wait_done(input logic need0, input logic need1, output int first);
    logic seen0;
    logic seen1;
    seen0 = !need0;
    seen1 = !need1;
    first = -1;
    while (!(seen0 && seen1)) begin
      @(negedge clk);
      if (done0 && !seen0) begin
        seen0 = 1'b1;
        first = (first < 0) ? 0 : first;
      end
      if (done1 && !seen1) begin
        seen1 = 1'b1;
        first = (first < 0) ? 1 : first;
      end
    end
  endtask

  task automatic report_test(input int num, input string name);
    if (errors == test_errors) begin
      $display("Test %0d, %s: ok", num, name);
    end else begin
      failed_tests++;
      $display("Test %0d, %s: %0d errors", num, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  task automatic single_run(input int base_word);
    int first;
    start_pair(1'b1, 1'b0, byte_addr(base_word), '0, '1, '0);
    wait_done(1'b1, 1'b0, first);
    model_run(1'b0, base_word, '1);
    check_count(32'(beat_count0), RUN_WORDS, RUN_WORDS, "beat_count0");
    check_flag(1'b0, error0, "error0");
    check_memory();
  endtask

  initial begin
    int b0;
    int b1;
    int first;
    logic [DATA_BYTES-1:0] mask;
    rst = 1'b1;
    start0 = 1'b0;
    start1 = 1'b0;
    base_addr0 = '0;
    base_addr1 = '0;
    byte_mask0 = '0;
    byte_mask1 = '0;
    dbg_addr = '0;
    rng = 32'h620f;
    errors = 0;
    test_errors = 0;
    failed_tests = 0;
    for (int w = 0; w < MEM_DEPTH; w++) begin
      model[w] = '0;
      known[w] = '0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    b0 = pick(MEM_DEPTH - RUN_WORDS + 1);
    single_run(b0);
    report_test(1, "single writer, full mask");

    // Same region again, so every untouched byte has a known old value.
    for (int r = 0; r < 2; r++) begin
      mask = partial_mask();
      start_pair(1'b1, 1'b0, byte_addr(b0), '0, mask, '0);
      wait_done(1'b1, 1'b0, first);
      model_run(1'b0, b0, mask);
      check_flag(1'b0, error0, "error0");
    end
    check_memory();
    report_test(2, "random partial masks");

    b0 = pick(MEM_DEPTH / 2 - RUN_WORDS + 1);
    b1 = MEM_DEPTH / 2 + pick(MEM_DEPTH / 2 - RUN_WORDS + 1);
    start_pair(1'b1, 1'b1, byte_addr(b0), byte_addr(b1), '1, '1);
    wait_done(1'b1, 1'b1, first);
    model_run(1'b0, b0, '1);
    model_run(1'b1, b1, '1);
    check_count(32'(beat_count0), RUN_WORDS, RUN_WORDS, "beat_count0");
    check_count(32'(beat_count1), RUN_WORDS, RUN_WORDS, "beat_count1");
    check_count(cycle_count0, RUN_WORDS, 32'hffff_ffff, "cycle_count0");
    check_count(cycle_count1, RUN_WORDS, 32'hffff_ffff, "cycle_count1");
    check_flag(1'b0, error0, "error0");
    check_flag(1'b0, error1, "error1");
    check_memory();
    report_test(3, "two writers, disjoint regions");

    // Final burst of writer 1 lands on the first burst of writer 0.
    b0 = (NUM_BURSTS - 1) * BURST_LEN
       + pick(MEM_DEPTH - RUN_WORDS - (NUM_BURSTS - 1) * BURST_LEN + 1);
    b1 = b0 - (NUM_BURSTS - 1) * BURST_LEN;
    start_pair(1'b1, 1'b0, byte_addr(b0), byte_addr(b1), '1, '1);
    repeat (1 + pick(8)) @(posedge clk);
    start_pair(1'b0, 1'b1, byte_addr(b0), byte_addr(b1), '1, '1);
    wait_done(1'b1, 1'b1, first);
    model_run(first == 1, first == 1 ? b1 : b0, '1);
    model_run(first != 1, first == 1 ? b0 : b1, '1);
    check_flag(1'b0, error0, "error0");
    check_flag(1'b0, error1, "error1");
    check_memory();
    report_test(4, "overlapping regions, staggered starts");

    // Writer 1 aims at an alias of writer 0's words, so a stray write would show.
    b0 = pick(MEM_DEPTH - RUN_WORDS + 1);
    b1 = MEM_DEPTH * (1 + pick((1 << ADDR_WIDTH) / (DATA_BYTES * MEM_DEPTH) - 1)) + b0;
    start_pair(1'b1, 1'b1, byte_addr(b0), byte_addr(b1), '1, '1);
    wait_done(1'b1, 1'b1, first);
    model_run(1'b0, b0, '1);
    check_flag(1'b0, error0, "error0");
    check_flag(1'b1, error1, "error1");
    check_count(32'(beat_count0), RUN_WORDS, RUN_WORDS, "beat_count0");
    check_count(32'(beat_count1), RUN_WORDS, RUN_WORDS, "beat_count1");
    check_memory();
    report_test(5, "out-of-range base on writer 1");

    // Words hit by the cut-off run hold a partial write.
    b0 = pick(MEM_DEPTH - RUN_WORDS + 1);
    start_pair(1'b1, 1'b0, byte_addr(b0), '0, '1, '0);
    repeat (8 + pick(24)) @(posedge clk);
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    for (int w = b0; w < b0 + RUN_WORDS; w++) begin
      known[w] = '0;
    end
    check_flag(1'b0, done0, "done0");
    check_flag(1'b0, done1, "done1");
    check_flag(1'b0, error0, "error0");
    check_flag(1'b0, error1, "error1");
    check_count(32'(beat_count0), 0, 0, "beat_count0");
    check_count(cycle_count0, 0, 0, "cycle_count0");
    check_count(32'(beat_count1), 0, 0, "beat_count1");
    check_count(cycle_count1, 0, 0, "cycle_count1");
    single_run(b0);
    report_test(6, "reset mid-run, then fresh run");

    $display("Tests run: %0d, failed: %0d, errors: %0d", NUM_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
hw/axi_perf_pkg.sv
hw/axi_burst_writer.sv
hw/axi_write_arbiter.sv
hw/axi_mem_sink.sv
hw/axi_perf_top.sv
sim/axi_perf_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module axi_perf_tb \
  -o axi_perf_sim > build.log 2>&1 &&
./obj_dir/axi_perf_sim > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
